// File: include/ahb_input_settings.svh
/*
 * AHB input stage settings
 * Bus widths, HTRANS/HBURST/HRESP encodings and the wrap check width
 */
`ifndef AHB_INPUT_SETTINGS_SVH
`define AHB_INPUT_SETTINGS_SVH

// Bus widths
`define AHB_ADDR_W    32        // HADDR
`define AHB_PROT_W    4         // HPROT
`define AHB_MASTER_W  4         // HMASTER

// HTRANS codes
`define TRN_IDLE      2'b00
`define TRN_BUSY      2'b01
`define TRN_NONSEQ    2'b10
`define TRN_SEQ       2'b11     // Bit 1 set on both active types

// HBURST codes
`define BUR_SINGLE    3'b000
`define BUR_INCR      3'b001    // Undefined length, used on resume
`define BUR_WRAP4     3'b010
`define BUR_INCR4     3'b011
`define BUR_WRAP8     3'b100
`define BUR_INCR8     3'b101
`define BUR_WRAP16    3'b110
`define BUR_INCR16    3'b111

// HRESP codes, AHB-Lite style
`define RSP_OKAY      2'b00
`define RSP_ERROR     2'b01

// Beat offset bits looked at for wrap boundaries, enough for WRAP16
`define WRAP_CHK_W    4

`endif

// File: hw/ahb_input_pkg.sv
/*
 * AHB input stage package
 * Vector types for the AHB fields and the packed address phase
 * and response groups shared by all blocks of the input stage
 */
`include "ahb_input_settings.svh"

package ahb_input_pkg;

  // ----------------------------------------------------------
  // Field types
  // ----------------------------------------------------------
  typedef logic [`AHB_ADDR_W-1:0]   haddr_t;   // Byte address
  typedef logic [1:0]               htrans_t;  // IDLE/BUSY/NONSEQ/SEQ
  typedef logic [2:0]               hsize_t;   // Log2 of bytes per beat
  typedef logic [2:0]               hburst_t;  // Burst kind and length
  typedef logic [`AHB_PROT_W-1:0]   hprot_t;
  typedef logic [`AHB_MASTER_W-1:0] hmaster_t; // Master number
  typedef logic [1:0]               hresp_t;   // OKAY or ERROR only

  // ----------------------------------------------------------
  // Address phase, one transfer
  // ----------------------------------------------------------
  // 51 bits with the default widths
  typedef struct packed {
    logic     sel;      // Port select
    haddr_t   addr;
    htrans_t  trans;
    logic     write;    // 1 = write
    hsize_t   size;
    hburst_t  burst;
    hprot_t   prot;
    hmaster_t master;
    logic     mastlock; // Locked sequence
  } ahb_ctrl_t;

  // ----------------------------------------------------------
  // Data phase response
  // ----------------------------------------------------------
  typedef struct packed {
    logic   readyout;   // Low inserts a wait state
    hresp_t resp;
  } ahb_rsp_t;

endpackage

// File: hw/ahb_hold_register.sv
/*
 * AHB holding register
 * Captures each accepted address phase, tracks whether it is still
 * waiting for the output stage, and selects direct or held control
 */
`include "ahb_input_settings.svh"

module ahb_hold_register
(
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  ahb_input_pkg::ahb_ctrl_t hs_ctrl,     // Live address phase
  input  logic                     HREADYS,
  input  logic                     active_ip,   // Output stage granted
  input  logic                     op_ready,    // Slave HREADYOUT
  output logic                     load,        // Accept strobe
  output logic                     addr_valid,
  output logic                     pend,        // Held transfer waiting
  output logic                     held_tran,   // Request to arbitration
  output ahb_input_pkg::ahb_ctrl_t ctrl_int,    // Direct or held control
  output ahb_input_pkg::htrans_t   trans_b      // Original HTRANS
);

  ahb_input_pkg::ahb_ctrl_t ctrl_hold;  // Captured address phase
  logic                     pend_next;

  // ----------------------------------------------------------
  // Accept
  // ----------------------------------------------------------
  // Selected and NONSEQ or SEQ
  assign addr_valid = hs_ctrl.sel & hs_ctrl.trans[1];

  // Only counts once the previous data phase has ended
  assign load = addr_valid & HREADYS;

  // Capture on every accept; only read back while pend is set
  always_ff @(posedge HCLK)
  begin
    if (load)
      ctrl_hold <= hs_ctrl;
  end

  // ----------------------------------------------------------
  // Pending flag
  // ----------------------------------------------------------
  // Set when the output stage is busy elsewhere at the accept,
  // cleared once the held transfer completes its address phase
  always_comb
  begin
    if (load && !active_ip)
      pend_next = 1'b1;
    else if (active_ip && op_ready)
      pend_next = 1'b0;
    else
      pend_next = pend;                     // Keep waiting
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend <= 1'b0;
    else
      pend <= pend_next;
  end

  // Live accept or something sitting in the register
  assign held_tran = load | pend;

  // ----------------------------------------------------------
  // Control mux
  // ----------------------------------------------------------
  always_comb
  begin
    if (pend)
    begin
      ctrl_int       = ctrl_hold;
      ctrl_int.sel   = 1'b1;                // Replay always selected
      ctrl_int.trans = `TRN_NONSEQ;         // Restarts as a new transfer
    end
    else
      ctrl_int = hs_ctrl;                   // Straight through
  end

  // Unmodified HTRANS, used to decide on the HBURST override
  assign trans_b = pend ? ctrl_hold.trans : hs_ctrl.trans;

  // Pending state can only come from an accept refused downstream
  a_pend_after_load : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $rose(pend) |-> $past(load)
  );

endmodule

// File: hw/ahb_burst_terminate.sv
/*
 * AHB early burst termination
 * Tracks bursts cut short by the output stage, turns resumed beats
 * into INCR, and restarts wrapping bursts that pass their boundary
 */
`include "ahb_input_settings.svh"

module ahb_burst_terminate
(
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  ahb_input_pkg::ahb_ctrl_t hs_ctrl,    // Live address phase
  input  logic                     HREADYS,
  input  logic                     load,       // Accept strobe
  input  logic                     active_ip,
  input  ahb_input_pkg::htrans_t   trans_int,  // Muxed HTRANS
  input  ahb_input_pkg::hburst_t   burst_int,  // Muxed HBURST
  input  ahb_input_pkg::htrans_t   trans_b,    // Original HTRANS
  output ahb_input_pkg::htrans_t   trans_out,
  output ahb_input_pkg::hburst_t   burst_out
);

  logic                   burst_override;  // Burst was broken up
  logic                   override_next;
  logic                   bound;           // Last beat before the wrap
  logic                   bound_next;
  logic [`WRAP_CHK_W-1:0] offset_addr;     // Beat index within the block
  logic [`WRAP_CHK_W-1:0] check_addr;

  // ----------------------------------------------------------
  // Override flag
  // ----------------------------------------------------------
  always_comb
  begin
    if (hs_ctrl.trans == `TRN_NONSEQ || hs_ctrl.trans == `TRN_IDLE)
      override_next = 1'b0;                 // New burst or bus idle
    else if (hs_ctrl.trans == `TRN_SEQ && load && !active_ip)
      override_next = 1'b1;                 // Mid-burst beat held back
    else
      override_next = burst_override;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (HREADYS)
      burst_override <= override_next;
  end

  // ----------------------------------------------------------
  // Wrap boundary check
  // ----------------------------------------------------------
  // Address scaled down to beats; wider than 64 bits treated as bytes
  always_comb
  begin
    case (hs_ctrl.size)
      3'b001  : offset_addr = hs_ctrl.addr[1 +: `WRAP_CHK_W];
      3'b010  : offset_addr = hs_ctrl.addr[2 +: `WRAP_CHK_W];
      3'b011  : offset_addr = hs_ctrl.addr[3 +: `WRAP_CHK_W];
      default : offset_addr = hs_ctrl.addr[0 +: `WRAP_CHK_W];
    endcase
  end

  // Bits above the wrap length forced high
  always_comb
  begin
    case (hs_ctrl.burst)
      `BUR_WRAP4  : check_addr = offset_addr | ({`WRAP_CHK_W{1'b1}} << 2);
      `BUR_WRAP8  : check_addr = offset_addr | ({`WRAP_CHK_W{1'b1}} << 3);
      `BUR_WRAP16 : check_addr = offset_addr;
      default     : check_addr = '0;        // Never wraps
    endcase
  end

  assign bound_next = &check_addr;

  // Sampled on every active beat of this port
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (hs_ctrl.trans[1] && HREADYS)
      bound <= bound_next;
  end

  // ----------------------------------------------------------
  // Fix-up
  // ----------------------------------------------------------
  // SEQ -> NONSEQ, BUSY -> IDLE past the boundary
  assign trans_out = (burst_override && bound) ? {trans_int[1], 1'b0} : trans_int;

  // Remaining beats become undefined length
  assign burst_out = (burst_override && trans_b != `TRN_NONSEQ) ? `BUR_INCR : burst_int;

  // A resumed burst must not reach the slave as a wrapping one
  a_no_wrap_on_resume : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (burst_override && trans_b != `TRN_NONSEQ)
      |-> !(burst_out inside {`BUR_WRAP4, `BUR_WRAP8, `BUR_WRAP16})
  );

endmodule

// File: hw/ahb_response_mux.sv
/*
 * AHB response mux
 * Follows the data phase of this port and picks HREADYOUTS/HRESPS
 */
`include "ahb_input_settings.svh"

module ahb_response_mux
(
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  logic                    addr_valid,  // Active address phase
  input  logic                    HREADYS,
  input  logic                    pend,        // Transfer still held
  input  ahb_input_pkg::ahb_rsp_t op_rsp,      // From the slave
  output ahb_input_pkg::ahb_rsp_t hs_rsp       // To the master
);

  logic data_valid;  // Data phase of an active transfer

  // Address phase moves into data phase when HREADYS is high
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

  // ----------------------------------------------------------
  // Response select
  // ----------------------------------------------------------
  always_comb
  begin
    if (!data_valid)
      hs_rsp = '{readyout: 1'b1, resp: `RSP_OKAY};   // Idle, busy or unselected
    else if (pend)
      hs_rsp = '{readyout: 1'b0, resp: `RSP_OKAY};   // Wait for the output stage
    else
      hs_rsp = op_rsp;                               // Slave answers directly
  end

  // Slave errors cannot leak through while a transfer is held
  a_okay_while_pend : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    pend |-> hs_rsp.resp == `RSP_OKAY
  );

endmodule

// File: hw/ahb_input_stage.sv
/*
 * AHB input stage
 * Holds a transfer that the output stage cannot take yet, requests
 * arbitration for it, replays it, and patches HTRANS/HBURST of
 * interrupted bursts before they reach the output stage
 */

module ahb_input_stage
(
  input  logic                   HCLK,
  input  logic                   HRESETn,
  // Upstream master side
  input  ahb_input_pkg::ahb_ctrl_t hs_ctrl,   // Address phase from master
  input  logic                   HREADYS,     // Bus-wide HREADY
  output ahb_input_pkg::ahb_rsp_t  hs_rsp,    // HREADYOUTS/HRESPS
  // Output stage side
  input  logic                   active_ip,   // Output stage owned by this port
  input  ahb_input_pkg::ahb_rsp_t  op_rsp,    // Slave ready/response
  output ahb_input_pkg::ahb_ctrl_t ip_ctrl,   // Transfer toward output stage
  output logic                   held_tran    // Arbitration request
);

  // ----------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------
  logic                     load;        // Accept strobe
  logic                     addr_valid;  // Active transfer to this port
  logic                     pend;        // Transfer waiting in hold reg
  ahb_input_pkg::ahb_ctrl_t ctrl_int;    // Direct or held, before fix-up
  ahb_input_pkg::htrans_t   trans_b;     // Original HTRANS for burst fix
  ahb_input_pkg::htrans_t   trans_out;
  ahb_input_pkg::hburst_t   burst_out;

  // Holding register and pending flag
  ahb_hold_register i_ahb_hold_register
  (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .hs_ctrl    (hs_ctrl),
    .HREADYS    (HREADYS),
    .active_ip  (active_ip),
    .op_ready   (op_rsp.readyout),
    .load       (load),
    .addr_valid (addr_valid),
    .pend       (pend),
    .held_tran  (held_tran),
    .ctrl_int   (ctrl_int),
    .trans_b    (trans_b)
  );

  // Early burst termination
  ahb_burst_terminate i_ahb_burst_terminate
  (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hs_ctrl   (hs_ctrl),
    .HREADYS   (HREADYS),
    .load      (load),
    .active_ip (active_ip),
    .trans_int (ctrl_int.trans),
    .burst_int (ctrl_int.burst),
    .trans_b   (trans_b),
    .trans_out (trans_out),
    .burst_out (burst_out)
  );

  // Response back to the master
  ahb_response_mux i_ahb_response_mux
  (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .addr_valid (addr_valid),
    .HREADYS    (HREADYS),
    .pend       (pend),
    .op_rsp     (op_rsp),
    .hs_rsp     (hs_rsp)
  );

  // Patched HTRANS/HBURST replace the raw fields
  always_comb
  begin
    ip_ctrl       = ctrl_int;
    ip_ctrl.trans = trans_out;
    ip_ctrl.burst = burst_out;
  end

endmodule

// File: testbench/tb_ahb_input_stage.sv
/*
 * Testbench for the AHB input stage
 * Replays per-cycle vectors from the stimulus file and checks the
 * master response, the control toward the output stage and held_tran
 */
`include "ahb_input_settings.svh"

module tb_ahb_input_stage;

  localparam string STIM_FILE    = "testbench/ahb_input_stimulus.txt";
  localparam int    CLK_PERIOD   = 10;
  localparam int    RESET_CYCLES = 4;

  // ----------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------
  logic                     HCLK;
  logic                     HRESETn;
  ahb_input_pkg::ahb_ctrl_t hs_ctrl;
  logic                     HREADYS;
  logic                     active_ip;
  ahb_input_pkg::ahb_rsp_t  op_rsp;
  ahb_input_pkg::ahb_rsp_t  hs_rsp;
  ahb_input_pkg::ahb_ctrl_t ip_ctrl;
  logic                     held_tran;

  // One line of the stimulus file
  typedef struct packed {
    ahb_input_pkg::ahb_ctrl_t ctrl;       // Master address phase
    logic                     hreadys;
    logic                     active;
    ahb_input_pkg::ahb_rsp_t  op;         // Output stage response
    ahb_input_pkg::ahb_rsp_t  exp_rsp;
    ahb_input_pkg::htrans_t   exp_trans;
    ahb_input_pkg::hburst_t   exp_burst;
    logic                     exp_sel;
    ahb_input_pkg::haddr_t    exp_addr;
    logic                     exp_held;
  } vector_t;

  vector_t                  vectors[$];
  ahb_input_pkg::ahb_ctrl_t last_accept;  // Most recent accepted address phase
  int                       num_checks;
  int                       num_errors;
  bit                       loaded;      // Vectors in memory, watchdog may start
  bit                       file_ok;

  ahb_input_stage i_ahb_input_stage
  (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hs_ctrl   (hs_ctrl),
    .HREADYS   (HREADYS),
    .hs_rsp    (hs_rsp),
    .active_ip (active_ip),
    .op_rsp    (op_rsp),
    .ip_ctrl   (ip_ctrl),
    .held_tran (held_tran)
  );

  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  // ----------------------------------------------------------
  // Stimulus file
  // ----------------------------------------------------------
  task automatic read_vectors(output bit ok);
    int          fd;
    int          n;
    int          line_no;
    string       line;
    logic [31:0] f [20];
    vector_t     v;
    ok      = 1'b1;
    line_no = 0;
    fd      = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      ok = 1'b0;
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      line_no++;
      if (line.len() < 2 || line.getc(0) == "#")
        continue;                                 // Blank or comment
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                  f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
      if (n != 20)
      begin
        $display("Malformed stimulus line %0d in %s, found %0d of 20 fields",
                 line_no, STIM_FILE, n);
        ok = 1'b0;
        break;
      end
      v.ctrl.sel          = f[0][0];
      v.ctrl.addr         = f[1];
      v.ctrl.trans        = f[2][1:0];
      v.ctrl.write        = f[3][0];
      v.ctrl.size         = f[4][2:0];
      v.ctrl.burst        = f[5][2:0];
      v.ctrl.prot         = f[6][`AHB_PROT_W-1:0];
      v.ctrl.master       = f[7][`AHB_MASTER_W-1:0];
      v.ctrl.mastlock     = f[8][0];
      v.hreadys           = f[9][0];
      v.active            = f[10][0];
      v.op.readyout       = f[11][0];
      v.op.resp           = f[12][1:0];
      v.exp_rsp.readyout  = f[13][0];             // Expected side
      v.exp_rsp.resp      = f[14][1:0];
      v.exp_trans         = f[15][1:0];
      v.exp_burst         = f[16][2:0];
      v.exp_sel           = f[17][0];
      v.exp_addr          = f[18];
      v.exp_held          = f[19][0];
      vectors.push_back(v);
    end
    $fclose(fd);
    if (ok && vectors.size() == 0)
    begin
      $display("No vectors found in stimulus file %s", STIM_FILE);
      ok = 1'b0;
    end
  endtask

  // ----------------------------------------------------------
  // Drive and check
  // ----------------------------------------------------------
  task automatic apply_vector(input vector_t v);
    hs_ctrl   = v.ctrl;
    HREADYS   = v.hreadys;
    active_ip = v.active;
    op_rsp    = v.op;
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    num_checks++;
    if (actual !== expected)
    begin
      num_errors++;
      $display("CHECK FAILED at time %0t: %s is 'h%0h, expected 'h%0h",
               $time, what, actual, expected);
    end
  endtask

  task automatic compare_outputs(input int idx, input vector_t v);
    string                    tag;
    ahb_input_pkg::ahb_ctrl_t src;
    tag = $sformatf("vector %0d", idx + 1);
    // Other fields come from the live phase or from the held one
    src = (v.exp_addr === v.ctrl.addr) ? v.ctrl : last_accept;
    check_value({tag, " hs_rsp.readyout"}, 32'(hs_rsp.readyout), 32'(v.exp_rsp.readyout));
    check_value({tag, " hs_rsp.resp"}, 32'(hs_rsp.resp), 32'(v.exp_rsp.resp));
    check_value({tag, " ip_ctrl.trans"}, 32'(ip_ctrl.trans), 32'(v.exp_trans));
    check_value({tag, " ip_ctrl.burst"}, 32'(ip_ctrl.burst), 32'(v.exp_burst));
    check_value({tag, " ip_ctrl.sel"}, 32'(ip_ctrl.sel), 32'(v.exp_sel));
    check_value({tag, " ip_ctrl.addr"}, ip_ctrl.addr, v.exp_addr);
    check_value({tag, " ip_ctrl.write"}, 32'(ip_ctrl.write), 32'(src.write));
    check_value({tag, " ip_ctrl.size"}, 32'(ip_ctrl.size), 32'(src.size));
    check_value({tag, " ip_ctrl.prot"}, 32'(ip_ctrl.prot), 32'(src.prot));
    check_value({tag, " ip_ctrl.master"}, 32'(ip_ctrl.master), 32'(src.master));
    check_value({tag, " ip_ctrl.mastlock"}, 32'(ip_ctrl.mastlock), 32'(src.mastlock));
    check_value({tag, " held_tran"}, 32'(held_tran), 32'(v.exp_held));
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial
  begin
    HCLK      = 1'b0;
    HRESETn   = 1'b0;                             // Held low for the reset cycles
    hs_ctrl   = '0;
    HREADYS   = 1'b1;
    active_ip = 1'b0;
    op_rsp    = '{readyout: 1'b1, resp: `RSP_OKAY};
    last_accept = '0;
    num_checks = 0;
    num_errors = 0;
    loaded     = 1'b0;
    read_vectors(file_ok);
    if (!file_ok)
    begin
      $display("Stimulus could not be loaded, no vectors were run");
      $display("tests failed");
      $finish;
    end
    else
    begin
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge HCLK);
      #1;
      HRESETn = 1'b1;
      foreach (vectors[i])
      begin
        apply_vector(vectors[i]);                 // 1 unit after the edge
        #(CLK_PERIOD - 2);
        compare_outputs(i, vectors[i]);           // Just before the next edge
        // Selected NONSEQ/SEQ with HREADYS high is taken
        if (vectors[i].ctrl.sel && vectors[i].ctrl.trans[1] && vectors[i].hreadys)
          last_accept = vectors[i].ctrl;
        @(posedge HCLK);
        #1;
      end
      $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
      if (num_errors == 0)
        $display("all tests passed");
      else
        $display("tests failed");
      $finish;
    end
  end

  // Watchdog sized from the vector count
  initial
  begin
    wait (loaded);
    #((vectors.size() + 20) * CLK_PERIOD);
    $display("Timeout, the vector run did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+include
hw/ahb_input_pkg.sv
hw/ahb_hold_register.sv
hw/ahb_burst_terminate.sv
hw/ahb_response_mux.sv
hw/ahb_input_stage.sv
testbench/tb_ahb_input_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AHB input stage testbench with Verilator
set -euo pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_ahb_input_stage \
  -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -q "tests failed" "$LOG"; then
  echo "Simulation FAILED, see $LOG"
  exit 1
fi

echo "Simulation PASSED"

// File: testbench/ahb_input_stimulus.txt
# in : sel addr trans write size burst prot master lock hreadys active_ip op_ready op_resp
# exp: readyout resp trans burst sel addr held_tran
# Idle after reset
0 00001000 0 0 2 0 3 1 0 1 0 1 0   1 0 0 0 0 00001000 0
1 00002000 0 0 2 0 3 1 0 1 1 1 0   1 0 0 0 1 00002000 0
# NONSEQ straight through, two-cycle ERROR response
1 00000100 2 1 2 0 3 1 0 1 1 1 0   1 0 2 0 1 00000100 1
1 00000104 0 0 2 0 3 1 0 0 1 0 1   0 1 0 0 1 00000104 0
1 00000104 0 0 2 0 3 1 0 1 1 1 1   1 1 0 0 1 00000104 0
# NONSEQ held until the output stage is granted and ready
1 00000200 2 0 2 0 3 1 0 1 0 1 0   1 0 2 0 1 00000200 1
1 00000204 0 0 2 0 3 1 0 0 0 1 0   0 0 2 0 1 00000200 1
1 00000204 0 0 2 0 3 1 0 0 1 0 0   0 0 2 0 1 00000200 1
1 00000204 0 0 2 0 3 1 0 0 1 1 0   0 0 2 0 1 00000200 1
1 00000204 0 0 2 0 3 1 0 1 1 1 0   1 0 0 0 1 00000204 0
# INCR4 broken on a SEQ beat, resumed as INCR
1 00000300 2 1 2 3 3 1 0 1 1 1 0   1 0 2 3 1 00000300 1
1 00000304 3 1 2 3 3 1 0 1 0 1 0   1 0 3 3 1 00000304 1
1 00000308 3 1 2 3 3 1 0 0 0 1 0   0 0 2 1 1 00000304 1
1 00000308 3 1 2 3 3 1 0 0 1 1 0   0 0 2 1 1 00000304 1
1 00000308 3 1 2 3 3 1 0 1 1 1 0   1 0 3 1 1 00000308 1
1 0000030c 3 1 2 3 3 1 0 1 1 1 0   1 0 3 1 1 0000030c 1
1 00000310 0 0 2 0 3 1 0 1 1 1 0   1 0 0 1 1 00000310 0
1 00000310 0 0 2 0 3 1 0 1 1 1 0   1 0 0 0 1 00000310 0
# WRAP4 word burst broken at offset 0xC, BUSY then SEQ past the wrap
1 00000408 2 0 2 2 3 1 0 1 1 1 0   1 0 2 2 1 00000408 1
1 0000040c 3 0 2 2 3 1 0 1 0 1 0   1 0 3 2 1 0000040c 1
1 00000400 1 0 2 2 3 1 0 0 0 1 0   0 0 2 1 1 0000040c 1
1 00000400 1 0 2 2 3 1 0 0 1 1 0   0 0 2 1 1 0000040c 1
1 00000400 1 0 2 2 3 1 0 1 1 1 0   1 0 0 1 1 00000400 0
1 00000400 3 0 2 2 3 1 0 1 1 1 0   1 0 2 1 1 00000400 1
1 00000404 3 0 2 2 3 1 0 1 1 1 0   1 0 3 1 1 00000404 1
0 00000000 0 0 0 0 0 0 0 1 1 1 0   1 0 0 1 0 00000000 0
0 00000000 0 0 0 0 0 0 0 1 1 1 0   1 0 0 0 0 00000000 0
# Unselected NONSEQ is not accepted
0 00000500 2 0 2 0 3 1 0 1 0 1 0   1 0 2 0 0 00000500 0
0 00000000 0 0 0 0 0 0 0 1 0 1 0   1 0 0 0 0 00000000 0
